// File: Makefile
SRCS := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: obj_dir/Vsoc_mem_tb

obj_dir/Vsoc_mem_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module soc_mem_tb

run: obj_dir/Vsoc_mem_tb
	./obj_dir/Vsoc_mem_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // load/store unit
    input  logic       l_arvalid,
    output logic       l_arready,
    input  addr_t      l_araddr,
    output logic       l_rvalid,
    input  logic       l_rready,
    output word_t      l_rdata,
    output resp_t      l_rresp,
    input  logic       l_awvalid,
    output logic       l_awready,
    input  addr_t      l_awaddr,
    input  logic       l_wvalid,
    output logic       l_wready,
    input  word_t      l_wdata,
    input  strb_t      l_wstrb,
    output logic       l_bvalid,
    input  logic       l_bready,
    output resp_t      l_bresp,
    // fetch unit, read only
    input  logic       i_arvalid,
    output logic       i_arready,
    input  addr_t      i_araddr,
    output logic       i_rvalid,
    input  logic       i_rready,
    output word_t      i_rdata,
    output resp_t      i_rresp,
    // slave
    output logic       s_arvalid,
    input  logic       s_arready,
    output addr_t      s_araddr,
    input  logic       s_rvalid,
    output logic       s_rready,
    input  word_t      s_rdata,
    input  resp_t      s_rresp,
    output logic       s_awvalid,
    input  logic       s_awready,
    output addr_t      s_awaddr,
    output logic       s_wvalid,
    input  logic       s_wready,
    output word_t      s_wdata,
    output strb_t      s_wstrb,
    input  logic       s_bvalid,
    output logic       s_bready,
    input  resp_t      s_bresp
);

    arb_state_t state;
    logic       gnt_l;
    logic       gnt_i;
    logic       done;

    assign gnt_l = state == arb_grant_lsu;
    assign gnt_i = state == arb_grant_ifu;
    // final beat of the granted transaction
    assign done  = (s_rvalid & s_rready) | (s_bvalid & s_bready);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arb_idle;
        end else begin
            case (state)
                arb_idle: begin
                    if (l_arvalid || l_awvalid) begin
                        state <= arb_grant_lsu;
                    end else if (i_arvalid) begin
                        state <= arb_grant_ifu;
                    end
                end
                default: begin
                    if (done) begin
                        state <= arb_idle;
                    end
                end
            endcase
        end
    end

    // toward the slave
    assign s_arvalid = (gnt_l & l_arvalid) | (gnt_i & i_arvalid);
    assign s_araddr  = gnt_i ? i_araddr : l_araddr;
    assign s_rready  = (gnt_l & l_rready) | (gnt_i & i_rready);
    assign s_awvalid = gnt_l & l_awvalid;
    assign s_awaddr  = l_awaddr;
    assign s_wvalid  = gnt_l & l_wvalid;
    assign s_wdata   = l_wdata;
    assign s_wstrb   = l_wstrb;
    assign s_bready  = gnt_l & l_bready;

    // back to the masters, the loser sees ready low
    assign l_arready = gnt_l & s_arready;
    assign l_rvalid  = gnt_l & s_rvalid;
    assign l_rdata   = s_rdata;
    assign l_rresp   = s_rresp;
    assign l_awready = gnt_l & s_awready;
    assign l_wready  = gnt_l & s_wready;
    assign l_bvalid  = gnt_l & s_bvalid;
    assign l_bresp   = s_bresp;
    assign i_arready = gnt_i & s_arready;
    assign i_rvalid  = gnt_i & s_rvalid;
    assign i_rdata   = s_rdata;
    assign i_rresp   = s_rresp;

endmodule

// File: src/clint_timer.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module clint_timer
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  clint_arvalid,
    input  addr_t clint_araddr,
    output logic  clint_arready,
    output logic  clint_rvalid,
    output word_t clint_rdata
);

    logic [63:0] mtime;
    addr_t       off;

    assign off           = clint_araddr - `CLINT_BASE;
    assign clint_arready = ~clint_rvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime        <= '0;
            clint_rvalid <= 1'b0;
        end else begin
            mtime        <= mtime + 64'd1;
            // answer is a single-cycle pulse
            clint_rvalid <= clint_arvalid & clint_arready;
        end
    end

    // offset bit 2 picks the upper half
    always_ff @(posedge clk) begin
        if (clint_arvalid && clint_arready) begin
            clint_rdata <= off[2] ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

// File: src/ifu_fetch.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module ifu_fetch
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  fetch,
    input  addr_t pc,
    output word_t inst,
    output logic  inst_valid,
    output logic  arvalid,
    input  logic  arready,
    output addr_t araddr,
    input  logic  rvalid,
    output logic  rready,
    input  word_t rdata,
    input  resp_t rresp
);

    addr_t pc_q;
    logic  wait_r;
    logic  busy;

    assign busy   = arvalid | wait_r;
    assign araddr = pc_q;
    assign rready = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            arvalid    <= 1'b0;
            wait_r     <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            if (fetch && !busy) begin
                arvalid <= 1'b1;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                wait_r  <= 1'b1;
            end
            if (wait_r && rvalid) begin
                wait_r     <= 1'b0;
                inst_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch && !busy) begin
            pc_q <= pc;
        end
        // all-zero word is an illegal instruction, so a faulted fetch traps later
        if (wait_r && rvalid) begin
            inst <= (rresp == `RESP_OKAY) ? rdata : '0;
        end
    end

endmodule

// File: src/lsu.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module lsu
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         ready,
    input  logic         ren,
    input  logic         wen,
    input  logic         sign,
    input  access_mask_t mask,
    input  addr_t        addr,
    input  word_t        wdata,
    output word_t        rdata,
    output logic         valid,
    output logic         bus_error,
    // bus master channels
    output logic         m_arvalid,
    input  logic         m_arready,
    output addr_t        m_araddr,
    input  logic         m_rvalid,
    output logic         m_rready,
    input  word_t        m_rdata,
    input  resp_t        m_rresp,
    output logic         m_awvalid,
    input  logic         m_awready,
    output addr_t        m_awaddr,
    output logic         m_wvalid,
    input  logic         m_wready,
    output word_t        m_wdata,
    output strb_t        m_wstrb,
    input  logic         m_bvalid,
    output logic         m_bready,
    input  resp_t        m_bresp,
    // private timer port
    output logic         clint_arvalid,
    input  logic         clint_arready,
    output addr_t        clint_araddr,
    input  logic         clint_rvalid,
    input  word_t        clint_rdata
);

    lsu_state_t   state;
    addr_t        addr_q;
    word_t        wdata_q;
    access_mask_t mask_q;
    logic         sign_q;
    logic         clint_q;
    logic         valid_q;
    word_t        rword_q;
    word_t        lane;
    logic [1:0]   off;
    logic         in_clint;
    logic         start;

    assign in_clint = (addr >= `CLINT_BASE) && (addr <= `CLINT_END);
    // no restart while the completion pulse is still out
    assign start    = (ren | wen) & ready & (state == lsu_idle) & ~valid_q;
    assign off      = addr_q[1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= lsu_idle;
            valid_q   <= 1'b0;
            bus_error <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                lsu_idle: begin
                    if (start && ren) begin
                        state <= lsu_read_addr;
                    end else if (start && !in_clint) begin
                        state <= lsu_write_addr;
                    end else if (start) begin
                        // timer writes are dropped and finish at once
                        valid_q <= 1'b1;
                    end
                end
                lsu_read_addr: begin
                    if (clint_q ? clint_arready : m_arready) begin
                        state <= lsu_read_data;
                    end
                end
                lsu_read_data: begin
                    if (clint_q ? clint_rvalid : m_rvalid) begin
                        state   <= lsu_idle;
                        valid_q <= 1'b1;
                        if (!clint_q && m_rresp != `RESP_OKAY) begin
                            bus_error <= 1'b1;
                        end
                    end
                end
                lsu_write_addr: begin
                    if (m_awready) begin
                        state <= lsu_write_data;
                    end
                end
                lsu_write_data: begin
                    if (m_wready) begin
                        state <= lsu_write_resp;
                    end
                end
                lsu_write_resp: begin
                    if (m_bvalid) begin
                        state   <= lsu_idle;
                        valid_q <= 1'b1;
                        if (m_bresp != `RESP_OKAY) begin
                            bus_error <= 1'b1;
                        end
                    end
                end
                default: state <= lsu_idle;
            endcase
        end
    end

    // request fields held for the whole access
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            mask_q  <= mask;
            sign_q  <= sign;
            clint_q <= in_clint;
        end
        if (state == lsu_read_data) begin
            if (clint_q && clint_rvalid) begin
                rword_q <= clint_rdata;
            end else if (!clint_q && m_rvalid) begin
                rword_q <= m_rdata;
            end
        end
    end

    assign m_arvalid     = (state == lsu_read_addr) & ~clint_q;
    assign m_araddr      = addr_q;
    assign m_rready      = 1'b1;
    assign m_awvalid     = state == lsu_write_addr;
    assign m_awaddr      = addr_q;
    assign m_wvalid      = state == lsu_write_data;
    assign m_wdata       = wdata_q << {off, 3'b000};
    assign m_bready      = 1'b1;
    assign clint_arvalid = (state == lsu_read_addr) & clint_q;
    assign clint_araddr  = addr_q;

    always_comb begin
        case (mask_q)
            2'd1:    m_wstrb = 4'b0001 << off;
            2'd2:    m_wstrb = off[1] ? 4'b1100 : 4'b0011;
            2'd3:    m_wstrb = 4'b1111;
            default: m_wstrb = 4'b0000;
        endcase
    end

    // move the addressed lane down, then extend
    assign lane = rword_q >> {off, 3'b000};

    always_comb begin
        case (mask_q)
            2'd1:    rdata = {{24{lane[7] & sign_q}}, lane[7:0]};
            2'd2:    rdata = {{16{lane[15] & sign_q}}, lane[15:0]};
            2'd3:    rdata = lane;
            default: rdata = '0;
        endcase
    end

    assign valid = (ren | wen) ? valid_q : ready;

endmodule

// File: src/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// sram window
`define MEM_BASE    32'h8000_0000
`define MEM_WORDS   1024

// machine timer, low word at base and high word at base + 4
`define CLINT_BASE  32'ha000_0048
`define CLINT_END   32'ha000_004f

// bus response codes
`define RESP_OKAY   2'd0
`define RESP_SLVERR 2'd2

`endif

// File: src/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    // 0 none, 1 byte, 2 half, 3 word
    typedef logic [1:0]  access_mask_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_grant_lsu,
        arb_grant_ifu
    } arb_state_t;

    typedef enum logic [2:0] {
        lsu_idle,
        lsu_read_addr,
        lsu_read_data,
        lsu_write_addr,
        lsu_write_data,
        lsu_write_resp
    } lsu_state_t;

endpackage

// File: src/soc_mem_top.sv
`timescale 1ns/1ps

module soc_mem_top
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         ready,
    input  logic         ren,
    input  logic         wen,
    input  logic         sign,
    input  access_mask_t mask,
    input  addr_t        addr,
    input  word_t        wdata,
    output word_t        rdata,
    output logic         valid,
    output logic         bus_error,
    input  logic         fetch,
    input  addr_t        pc,
    output word_t        inst,
    output logic         inst_valid
);

    // lsu to arbiter
    logic  l_arvalid, l_arready, l_rvalid, l_rready, l_awvalid, l_awready;
    logic  l_wvalid, l_wready, l_bvalid, l_bready;
    addr_t l_araddr, l_awaddr;
    word_t l_rdata, l_wdata;
    resp_t l_rresp, l_bresp;
    strb_t l_wstrb;

    // fetch to arbiter
    logic  i_arvalid, i_arready, i_rvalid, i_rready;
    addr_t i_araddr;
    word_t i_rdata;
    resp_t i_rresp;

    // arbiter to sram
    logic  s_arvalid, s_arready, s_rvalid, s_rready, s_awvalid, s_awready;
    logic  s_wvalid, s_wready, s_bvalid, s_bready;
    addr_t s_araddr, s_awaddr;
    word_t s_rdata, s_wdata;
    resp_t s_rresp, s_bresp;
    strb_t s_wstrb;

    // lsu to timer
    logic  clint_arvalid, clint_arready, clint_rvalid;
    addr_t clint_araddr;
    word_t clint_rdata;

    lsu u_lsu (
        .clk, .reset, .ready, .ren, .wen, .sign, .mask, .addr, .wdata,
        .rdata, .valid, .bus_error,
        .m_arvalid (l_arvalid), .m_arready (l_arready), .m_araddr (l_araddr),
        .m_rvalid  (l_rvalid),  .m_rready  (l_rready),  .m_rdata  (l_rdata),
        .m_rresp   (l_rresp),
        .m_awvalid (l_awvalid), .m_awready (l_awready), .m_awaddr (l_awaddr),
        .m_wvalid  (l_wvalid),  .m_wready  (l_wready),  .m_wdata  (l_wdata),
        .m_wstrb   (l_wstrb),
        .m_bvalid  (l_bvalid),  .m_bready  (l_bready),  .m_bresp  (l_bresp),
        .clint_arvalid, .clint_arready, .clint_araddr, .clint_rvalid, .clint_rdata
    );

    ifu_fetch u_ifu (
        .clk, .reset, .fetch, .pc, .inst, .inst_valid,
        .arvalid (i_arvalid), .arready (i_arready), .araddr (i_araddr),
        .rvalid  (i_rvalid),  .rready  (i_rready),  .rdata  (i_rdata),
        .rresp   (i_rresp)
    );

    bus_arbiter u_arb (.*);

    sram_slave u_sram (.*);

    clint_timer u_clint (.*);

endmodule

// File: src/sram_slave.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module sram_slave
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  s_arvalid,
    output logic  s_arready,
    input  addr_t s_araddr,
    output logic  s_rvalid,
    input  logic  s_rready,
    output word_t s_rdata,
    output resp_t s_rresp,
    input  logic  s_awvalid,
    output logic  s_awready,
    input  addr_t s_awaddr,
    input  logic  s_wvalid,
    output logic  s_wready,
    input  word_t s_wdata,
    input  strb_t s_wstrb,
    output logic  s_bvalid,
    input  logic  s_bready,
    output resp_t s_bresp
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    word_t mem [`MEM_WORDS];
    addr_t waddr_q;
    addr_t r_off;
    addr_t w_off;
    logic  r_hit;
    logic  w_hit;
    logic  busy_w;
    logic  idle;

    assign r_off = s_araddr - `MEM_BASE;
    assign w_off = waddr_q - `MEM_BASE;
    assign r_hit = (s_araddr >= `MEM_BASE) && (r_off < `MEM_WORDS * 4);
    assign w_hit = (waddr_q >= `MEM_BASE) && (w_off < `MEM_WORDS * 4);

    assign idle      = ~s_rvalid & ~s_bvalid & ~busy_w;
    assign s_arready = idle;
    // a read in the same cycle goes first
    assign s_awready = idle & ~s_arvalid;
    assign s_wready  = busy_w;

    always_ff @(posedge clk) begin
        if (reset) begin
            s_rvalid <= 1'b0;
            s_bvalid <= 1'b0;
            busy_w   <= 1'b0;
        end else begin
            if (s_arvalid && s_arready) begin
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
            if (s_awvalid && s_awready) begin
                busy_w <= 1'b1;
            end else if (s_wvalid) begin
                busy_w <= 1'b0;
            end
            if (s_wvalid && s_wready) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_arvalid && s_arready) begin
            s_rdata <= r_hit ? mem[r_off[IDX_W+1:2]] : '0;
            s_rresp <= r_hit ? `RESP_OKAY : `RESP_SLVERR;
        end
        if (s_awvalid && s_awready) begin
            waddr_q <= s_awaddr;
        end
        if (s_wvalid && s_wready) begin
            s_bresp <= w_hit ? `RESP_OKAY : `RESP_SLVERR;
        end
    end

    // byte lanes, writes outside the window are dropped
    always_ff @(posedge clk) begin
        if (s_wvalid && s_wready && w_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (s_wstrb[b]) begin
                    mem[w_off[IDX_W+1:2]][b*8 +: 8] <= s_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: tests/soc_mem_sva.sv
`timescale 1ns/1ps

module soc_mem_sva
    import mem_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  l_arvalid,
    input logic  l_arready,
    input addr_t l_araddr,
    input logic  l_rvalid,
    input logic  l_rready,
    input logic  l_awvalid,
    input logic  l_awready,
    input addr_t l_awaddr,
    input logic  l_wvalid,
    input logic  l_wready,
    input word_t l_wdata,
    input strb_t l_wstrb,
    input logic  l_bvalid,
    input logic  l_bready,
    input logic  i_arvalid,
    input logic  i_arready,
    input addr_t i_araddr,
    input logic  i_rvalid,
    input logic  i_rready
);

    // transaction accepted by the slave and not yet answered
    logic l_open;
    logic i_open;

    always_ff @(posedge clk) begin
        if (reset) begin
            l_open <= 1'b0;
            i_open <= 1'b0;
        end else begin
            if ((l_arvalid && l_arready) || (l_awvalid && l_awready)) begin
                l_open <= 1'b1;
            end else if ((l_rvalid && l_rready) || (l_bvalid && l_bready)) begin
                l_open <= 1'b0;
            end
            if (i_arvalid && i_arready) begin
                i_open <= 1'b1;
            end else if (i_rvalid && i_rready) begin
                i_open <= 1'b0;
            end
        end
    end

    // a waiting valid keeps its payload until the transfer
    lsu_ar_hold: assert property (@(posedge clk) disable iff (reset)
        l_arvalid && !l_arready |=> l_arvalid && $stable(l_araddr))
        else $error("lsu read address dropped or changed while waiting");

    lsu_aw_hold: assert property (@(posedge clk) disable iff (reset)
        l_awvalid && !l_awready |=> l_awvalid && $stable(l_awaddr))
        else $error("lsu write address dropped or changed while waiting");

    lsu_w_hold: assert property (@(posedge clk) disable iff (reset)
        l_wvalid && !l_wready |=> l_wvalid && $stable(l_wdata) && $stable(l_wstrb))
        else $error("lsu write data dropped or changed while waiting");

    ifu_ar_hold: assert property (@(posedge clk) disable iff (reset)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
        else $error("fetch read address dropped or changed while waiting");

    // only one master may have a transaction at the slave
    lsu_owns_slave: assert property (@(posedge clk) disable iff (reset)
        l_open |-> !i_arready && !i_rvalid)
        else $error("fetch channels forwarded while an lsu transaction is open");

    ifu_owns_slave: assert property (@(posedge clk) disable iff (reset)
        i_open |-> !l_arready && !l_awready && !l_rvalid && !l_bvalid)
        else $error("lsu channels forwarded while a fetch transaction is open");

endmodule

bind bus_arbiter soc_mem_sva u_sva (
    .clk, .reset, .l_arvalid, .l_arready, .l_araddr, .l_rvalid, .l_rready,
    .l_awvalid, .l_awready, .l_awaddr, .l_wvalid, .l_wready, .l_wdata,
    .l_wstrb, .l_bvalid, .l_bready, .i_arvalid, .i_arready, .i_araddr,
    .i_rvalid, .i_rready
);

// File: tests/soc_mem_tb.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module soc_mem_tb
    import mem_pkg::*;
;

    localparam int TIMEOUT = 200;

    logic         clk;
    logic         reset;
    logic         ready;
    logic         ren;
    logic         wen;
    logic         sign;
    access_mask_t mask;
    addr_t        addr;
    word_t        wdata;
    word_t        rdata;
    logic         valid;
    logic         bus_error;
    logic         fetch;
    addr_t        pc;
    word_t        inst;
    logic         inst_valid;

    // byte image of the sram
    logic [7:0]   model [`MEM_WORDS * 4];
    addr_t        words [$];
    string        test_name;
    int           errors;
    int           checks;
    int           test_errs;
    int           tests_run;
    int           tests_failed;

    soc_mem_top dut (.*);

    always #5 clk = ~clk;

    task automatic check_value(input string what, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: no %s within %0d cycles", test_name, what, TIMEOUT);
        errors++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errs) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - test_errs);
        end
    endtask

    // write data sits in the low lanes and lands at the address
    task automatic store_model(input addr_t a, input access_mask_t m, input word_t d);
        int i;
        i = a - `MEM_BASE;
        model[i] = d[7:0];
        if (m >= 2'd2) begin
            model[i+1] = d[15:8];
        end
        if (m == 2'd3) begin
            model[i+2] = d[23:16];
            model[i+3] = d[31:24];
        end
    endtask

    function automatic word_t expect_load(input addr_t a, input access_mask_t m,
                                          input logic sg);
        int    i;
        word_t v;
        i = a - `MEM_BASE;
        case (m)
            2'd1:    v = {{24{sg & model[i][7]}}, model[i]};
            2'd2:    v = {{16{sg & model[i+1][7]}}, model[i+1], model[i]};
            2'd3:    v = {model[i+3], model[i+2], model[i+1], model[i]};
            default: v = '0;
        endcase
        return v;
    endfunction

    // hold ren or wen until the valid pulse
    task automatic lsu_access(input logic wr, input access_mask_t m, input logic sg,
                              input addr_t a, input word_t d, output word_t result);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge clk);
        #1;
        ren   = ~wr;
        wen   = wr;
        mask  = m;
        sign  = sg;
        addr  = a;
        wdata = d;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            seen = valid;
        end
        result = rdata;
        ren    = 1'b0;
        wen    = 1'b0;
        if (!seen) begin
            report_timeout("lsu valid");
        end
    endtask

    task automatic fetch_word(input addr_t a, output word_t result, output int pulses);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        pulses = 0;
        @(posedge clk);
        #1;
        fetch = 1'b1;
        pc    = a;
        @(posedge clk);
        #1;
        fetch = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            seen = inst_valid;
        end
        result = inst;
        if (!seen) begin
            report_timeout("inst_valid");
        end else begin
            pulses = 1;
            repeat (4) begin
                @(posedge clk);
                #1;
                if (inst_valid) begin
                    pulses++;
                end
            end
        end
    endtask

    initial begin
        int           seed;
        int           pick;
        int           pulses;
        int           cycles;
        int           lsu_at;
        int           ifu_at;
        addr_t        wa;
        addr_t        sa;
        addr_t        ra;
        addr_t        off;
        access_mask_t sm;
        word_t        d;
        word_t        rd;
        word_t        t0;
        word_t        t1;
        word_t        lsu_val;
        word_t        ifu_val;

        seed  = $urandom(87);
        clk   = 1'b0;
        reset = 1'b1;
        ready = 1'b0;
        ren   = 1'b0;
        wen   = 1'b0;
        sign  = 1'b0;
        mask  = '0;
        addr  = '0;
        wdata = '0;
        fetch = 1'b0;
        pc    = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test("reset_state");
        @(negedge clk);
        check_value("valid", 32'd0, {31'd0, valid});
        check_value("inst_valid", 32'd0, {31'd0, inst_valid});
        check_value("bus_error", 32'd0, {31'd0, bus_error});
        @(posedge clk);
        #1;
        ready = 1'b1;
        @(negedge clk);
        check_value("valid follows ready high", 32'd1, {31'd0, valid});
        @(posedge clk);
        #1;
        ready = 1'b0;
        @(negedge clk);
        check_value("valid follows ready low", 32'd0, {31'd0, valid});
        @(posedge clk);
        #1;
        ready = 1'b1;
        end_test();

        begin_test("store_load");
        for (int n = 0; n < 6; n++) begin
            wa = `MEM_BASE + ($urandom % `MEM_WORDS) * 4;
            sm = access_mask_t'($urandom % 3 + 1);
            case (sm)
                2'd1:    off = $urandom % 4;
                2'd2:    off = ($urandom % 2) * 2;
                default: off = '0;
            endcase
            sa = wa + off;
            d  = $urandom;
            lsu_access(1'b1, 2'd3, 1'b0, wa, d, rd);
            store_model(wa, 2'd3, d);
            d = $urandom;
            lsu_access(1'b1, sm, 1'b0, sa, d, rd);
            store_model(sa, sm, d);
            words.push_back(wa);
            for (int rm = 1; rm <= 3; rm++) begin
                for (int sg = 0; sg < 2; sg++) begin
                    // align the read address to its own size
                    ra = (rm == 1) ? sa : (rm == 2) ? {sa[31:1], 1'b0} : wa;
                    lsu_access(1'b0, access_mask_t'(rm), sg[0], ra, '0, rd);
                    check_value($sformatf("load m%0d s%0d at %h", rm, sg, ra),
                                expect_load(ra, access_mask_t'(rm), sg[0]), rd);
                end
            end
        end
        end_test();

        begin_test("fetch");
        for (int n = 0; n < 5; n++) begin
            pick = $urandom % words.size();
            fetch_word(words[pick], rd, pulses);
            check_value($sformatf("inst at %h", words[pick]),
                        expect_load(words[pick], 2'd3, 1'b0), rd);
            check_value("inst_valid pulses", 32'd1, pulses);
        end
        end_test();

        begin_test("contention");
        wa = words[0];
        sa = words[words.size() - 1];
        @(posedge clk);
        #1;
        ren    = 1'b1;
        mask   = 2'd3;
        sign   = 1'b0;
        addr   = wa;
        fetch  = 1'b1;
        pc     = sa;
        lsu_at = 0;
        ifu_at = 0;
        cycles = 0;
        while ((lsu_at == 0 || ifu_at == 0) && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            fetch = 1'b0;
            if (ren && valid) begin
                lsu_at  = cycles;
                lsu_val = rdata;
                ren     = 1'b0;
            end
            if (inst_valid && ifu_at == 0) begin
                ifu_at  = cycles;
                ifu_val = inst;
            end
        end
        ren = 1'b0;
        if (lsu_at == 0 || ifu_at == 0) begin
            report_timeout("completion of both masters");
        end else begin
            check_value("lsu data", expect_load(wa, 2'd3, 1'b0), lsu_val);
            check_value("fetch data", expect_load(sa, 2'd3, 1'b0), ifu_val);
            check_value("lsu first", 32'd1, {31'd0, lsu_at < ifu_at});
        end
        end_test();

        begin_test("timer");
        lsu_access(1'b0, 2'd3, 1'b0, `CLINT_BASE, '0, t0);
        lsu_access(1'b0, 2'd3, 1'b0, `CLINT_BASE, '0, t1);
        check_value("low word increases", 32'd1, {31'd0, t1 > t0});
        lsu_access(1'b0, 2'd3, 1'b0, `CLINT_BASE + 32'd4, '0, rd);
        check_value("high word", 32'd0, rd);
        check_value("bus_error before fault", 32'd0, {31'd0, bus_error});
        end_test();

        begin_test("bus_error");
        lsu_access(1'b0, 2'd3, 1'b0, 32'h4000_0000, '0, rd);
        check_value("bus_error set", 32'd1, {31'd0, bus_error});
        d = $urandom;
        lsu_access(1'b1, 2'd3, 1'b0, words[0], d, rd);
        store_model(words[0], 2'd3, d);
        lsu_access(1'b0, 2'd3, 1'b0, words[0], '0, rd);
        check_value("good load", expect_load(words[0], 2'd3, 1'b0), rd);
        check_value("bus_error sticky", 32'd1, {31'd0, bus_error});
        end_test();

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/mem_pkg.sv
src/lsu.sv
src/ifu_fetch.sv
src/bus_arbiter.sv
src/sram_slave.sv
src/clint_timer.sv
src/soc_mem_top.sv
tests/soc_mem_sva.sv
tests/soc_mem_tb.sv
